// ==== design/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int xlen = 32;
    localparam int ilen = 32;
    localparam int alen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] xdata_t;
    typedef logic [ilen-1:0] instr_t;
    typedef logic [alen-1:0] addr_t;

    // instruction fields.
    typedef logic [11:0] i_imm_t;
    typedef logic [19:0] u_imm_t;
    typedef logic [19:0] j_imm_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    //////////////////////////////////////////////////////////////////////
    // major opcodes, instruction bits 6..2
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        op_load   = 5'b00_000,
        op_op_imm = 5'b00_100,
        op_auipc  = 5'b00_101,
        op_op     = 5'b01_100,
        op_lui    = 5'b01_101,
        op_store  = 5'b01_000,
        op_branch = 5'b11_000,
        op_jalr   = 5'b11_001,
        op_jal    = 5'b11_011,
        op_system = 5'b11_100
    } opcode_t;

endpackage

`default_nettype wire

// ==== design/skid_buffer.sv ====
`default_nettype none

module skid_buffer
    import decode_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,
    input  wire logic  prev_stalled,
    input  wire instr_t instruction,
    input  wire addr_t instruction_addr,
    input  wire addr_t instruction_next_addr,
    input  wire logic  ifetch_exception,
    input  wire logic  advance,
    output logic       stall_prev,
    output logic       have_item,
    output instr_t     buf_instruction,
    output addr_t      buf_addr,
    output addr_t      buf_next_addr,
    output logic       buf_exception
);

    logic   full;
    instr_t skid_instruction;
    addr_t  skid_addr;
    addr_t  skid_next_addr;
    logic   skid_exception;

    // fetch holds while the skid slot is occupied.
    assign stall_prev = full;
    assign have_item  = full || !prev_stalled;

    // empty slot lets the fetch bundle straight through.
    always_comb begin
        if (full) begin
            buf_instruction = skid_instruction;
            buf_addr        = skid_addr;
            buf_next_addr   = skid_next_addr;
            buf_exception   = skid_exception;
        end else begin
            buf_instruction = instruction;
            buf_addr        = instruction_addr;
            buf_next_addr   = instruction_next_addr;
            buf_exception   = ifetch_exception;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (full) begin
            if (advance) begin
                full <= 1'b0;
            end
        end else if (!prev_stalled && !advance) begin
            full <= 1'b1;
        end
    end

    // capture only when the item arrives and cannot move on.
    always_ff @(posedge clk) begin
        if (!full && !prev_stalled && !advance) begin
            skid_instruction <= instruction;
            skid_addr        <= instruction_addr;
            skid_next_addr   <= instruction_next_addr;
            skid_exception   <= ifetch_exception;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file
    import decode_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire reg_addr_t read1_sel,
    input  wire reg_addr_t read2_sel,
    output xdata_t         read1_data,
    output xdata_t         read2_data,
    input  wire reg_addr_t write_sel,
    input  wire xdata_t    write_data
);

    // x0 has no storage.
    xdata_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_sel != '0) begin
            regs[write_sel] <= write_data;
        end
    end

    // old value shows during a write, bypass covers it.
    always_comb begin
        if (read1_sel == '0) begin
            read1_data = '0;
        end else begin
            read1_data = regs[read1_sel];
        end
        if (read2_sel == '0) begin
            read2_data = '0;
        end else begin
            read2_data = regs[read2_sel];
        end
    end

endmodule

`default_nettype wire

// ==== design/field_decoder.sv ====
`default_nettype none

module field_decoder
    import decode_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   advance,
    input  wire instr_t buf_instruction,
    input  wire addr_t  buf_addr,
    input  wire addr_t  buf_next_addr,
    output opcode_t     opcode,
    output reg_addr_t   rd,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output funct3_t     funct3,
    output funct7_t     funct7,
    output i_imm_t      i_imm,
    output u_imm_t      u_imm,
    output j_imm_t      j_imm,
    output logic        is_jump,
    output logic        raw_reg_write,
    output logic        is_compressed,
    output addr_t       instruction_addr_q,
    output addr_t       instruction_next_addr_q
);

    opcode_t opcode_d;

    assign opcode_d = opcode_t'(buf_instruction[6:2]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode                  <= op_load;
            rd                      <= '0;
            rs1                     <= '0;
            rs2                     <= '0;
            funct3                  <= '0;
            funct7                  <= '0;
            i_imm                   <= '0;
            u_imm                   <= '0;
            j_imm                   <= '0;
            is_jump                 <= 1'b0;
            raw_reg_write           <= 1'b0;
            is_compressed           <= 1'b0;
            instruction_addr_q      <= '0;
            instruction_next_addr_q <= '0;
        end else if (advance) begin
            opcode <= opcode_d;
            rd     <= buf_instruction[11:7];
            rs1    <= buf_instruction[19:15];
            rs2    <= buf_instruction[24:20];
            funct3 <= buf_instruction[14:12];
            funct7 <= buf_instruction[31:25];
            i_imm  <= buf_instruction[31:20];
            u_imm  <= buf_instruction[31:12];
            // imm[20|10:1|11|19:12] reordered to imm[20:1].
            j_imm  <= {buf_instruction[31], buf_instruction[19:12],
                       buf_instruction[20], buf_instruction[30:25],
                       buf_instruction[24:21]};
            is_jump       <= buf_instruction[6:5] == 2'b11;
            raw_reg_write <= opcode_d != op_store && opcode_d != op_branch
                             && opcode_d != op_system;
            is_compressed <= buf_instruction[1:0] != 2'b11;
            instruction_addr_q      <= buf_addr;
            instruction_next_addr_q <= buf_next_addr;
        end
    end

endmodule

`default_nettype wire

// ==== design/operand_fetch.sv ====
`default_nettype none

module operand_fetch
    import decode_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      advance,
    input  wire instr_t    buf_instruction,
    output reg_addr_t      read1_sel,
    output reg_addr_t      read2_sel,
    input  wire xdata_t    read1_data,
    input  wire xdata_t    read2_data,
    input  wire reg_addr_t exec_reg,
    input  wire reg_addr_t wb_reg,
    input  wire xdata_t    exec_data,
    input  wire xdata_t    wb_data,
    output xdata_t         rs1_data,
    output xdata_t         rs2_data
);

    xdata_t rs1_sel_data;
    xdata_t rs2_sel_data;

    // exec is younger than writeback, so it wins.
    function automatic xdata_t pick_operand(
        input reg_addr_t src,
        input xdata_t    port_data,
        input reg_addr_t ex_sel,
        input xdata_t    ex_data,
        input reg_addr_t wr_sel,
        input xdata_t    wr_data
    );
        xdata_t result;
        if (src == '0) begin
            result = '0;
        end else if (ex_sel == src) begin
            result = ex_data;
        end else if (wr_sel == src) begin
            result = wr_data;
        end else begin
            result = port_data;
        end
        return result;
    endfunction

    assign read1_sel = buf_instruction[19:15];
    assign read2_sel = buf_instruction[24:20];

    assign rs1_sel_data = pick_operand(read1_sel, read1_data, exec_reg, exec_data,
                                       wb_reg, wb_data);
    assign rs2_sel_data = pick_operand(read2_sel, read2_data, exec_reg, exec_data,
                                       wb_reg, wb_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rs1_data <= '0;
            rs2_data <= '0;
        end else if (advance) begin
            rs1_data <= rs1_sel_data;
            rs2_data <= rs2_sel_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_commit.sv ====
`default_nettype none

module decode_commit (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic next_stalled,
    input  wire logic have_item,
    input  wire logic buf_exception,
    input  wire logic is_compressed,
    input  wire logic raw_reg_write,
    output logic      advance,
    output logic      stall_next,
    output logic      decode_exception,
    output logic      is_reg_write
);

    logic out_valid;
    logic fetch_exception_q;

    // output slot is free when empty or being taken this cycle.
    assign advance    = have_item && (!out_valid || !next_stalled);
    assign stall_next = !out_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= 1'b1;
        end else if (!next_stalled) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_exception_q <= 1'b0;
        end else if (advance) begin
            fetch_exception_q <= buf_exception;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // exception merge
    //////////////////////////////////////////////////////////////////////

    // compressed encodings are not decoded.
    assign decode_exception = fetch_exception_q || is_compressed;

    // a faulting instruction never writes rd.
    assign is_reg_write = raw_reg_write && !decode_exception;

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      flush,

    // fetch side.
    input  wire instr_t    instruction,
    input  wire addr_t     instruction_addr,
    input  wire addr_t     instruction_next_addr,
    input  wire logic      ifetch_exception,
    input  wire logic      prev_stalled,
    output logic           stall_prev,

    // exec side.
    input  wire logic      next_stalled,
    output logic           stall_next,

    // bypass and writeback.
    input  wire reg_addr_t exec_reg,
    input  wire xdata_t    exec_data,
    input  wire reg_addr_t wb_reg,
    input  wire xdata_t    wb_data,

    // decoded instruction.
    output opcode_t        opcode,
    output reg_addr_t      rd,
    output reg_addr_t      rs1,
    output reg_addr_t      rs2,
    output funct3_t        funct3,
    output funct7_t        funct7,
    output i_imm_t         i_imm,
    output u_imm_t         u_imm,
    output j_imm_t         j_imm,
    output logic           is_jump,
    output logic           is_compressed,
    output logic           is_reg_write,
    output logic           decode_exception,
    output addr_t          instruction_addr_q,
    output addr_t          instruction_next_addr_q,
    output xdata_t         rs1_data,
    output xdata_t         rs2_data
);

    logic      advance;
    logic      have_item;
    instr_t    buf_instruction;
    addr_t     buf_addr;
    addr_t     buf_next_addr;
    logic      buf_exception;
    reg_addr_t read1_sel;
    reg_addr_t read2_sel;
    xdata_t    read1_data;
    xdata_t    read2_data;
    logic      raw_reg_write;

    skid_buffer i_skid_buffer (
        .clk, .arst_n, .flush, .prev_stalled,
        .instruction, .instruction_addr, .instruction_next_addr, .ifetch_exception,
        .advance, .stall_prev, .have_item,
        .buf_instruction, .buf_addr, .buf_next_addr, .buf_exception
    );

    reg_file i_reg_file (
        .clk, .arst_n,
        .read1_sel, .read2_sel, .read1_data, .read2_data,
        .write_sel  (wb_reg),
        .write_data (wb_data)
    );

    field_decoder i_field_decoder (
        .clk, .arst_n, .advance,
        .buf_instruction, .buf_addr, .buf_next_addr,
        .opcode, .rd, .rs1, .rs2, .funct3, .funct7,
        .i_imm, .u_imm, .j_imm,
        .is_jump, .raw_reg_write, .is_compressed,
        .instruction_addr_q, .instruction_next_addr_q
    );

    operand_fetch i_operand_fetch (
        .clk, .arst_n, .advance, .buf_instruction,
        .read1_sel, .read2_sel, .read1_data, .read2_data,
        .exec_reg, .wb_reg, .exec_data, .wb_data,
        .rs1_data, .rs2_data
    );

    decode_commit i_decode_commit (
        .clk, .arst_n, .flush, .next_stalled, .have_item,
        .buf_exception, .is_compressed, .raw_reg_write,
        .advance, .stall_next, .decode_exception, .is_reg_write
    );

endmodule

`default_nettype wire

// ==== tb/tb_decode_stage.sv ====
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // summed test lengths in cycles, doubled for the watchdog.
    localparam int test_cycles = 40 + 210 + 60 + 20 + 330 + 60 + 40;
    localparam int cycle_limit = 2 * test_cycles;

    typedef struct packed {
        instr_t w;
        addr_t  a;
        addr_t  na;
        logic   fx;
        xdata_t v1;
        xdata_t v2;
    } item_t;

    logic      clk;
    logic      arst_n;
    logic      flush;
    instr_t    instruction;
    addr_t     instruction_addr;
    addr_t     instruction_next_addr;
    logic      ifetch_exception;
    logic      prev_stalled;
    logic      stall_prev;
    logic      next_stalled;
    logic      stall_next;
    reg_addr_t exec_reg;
    xdata_t    exec_data;
    reg_addr_t wb_reg;
    xdata_t    wb_data;
    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   funct3;
    funct7_t   funct7;
    i_imm_t    i_imm;
    u_imm_t    u_imm;
    j_imm_t    j_imm;
    logic      is_jump;
    logic      is_compressed;
    logic      is_reg_write;
    logic      decode_exception;
    addr_t     instruction_addr_q;
    addr_t     instruction_next_addr_q;
    xdata_t    rs1_data;
    xdata_t    rs2_data;

    int          errors = 0;
    int          cycles = 0;
    string       test_name = "reset";
    logic [31:0] rng_state = 32'd71467;
    item_t       exp_q[$];
    xdata_t      shadow [0:31];
    logic        accepted;
    logic        last_stall_prev;
    logic        last_stall_next;
    logic        last_next_stalled;

    decode_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: stage stopped producing outputs");
                $display("Something failed");
                $finish;
            end
        end
    end

    function automatic logic [31:0] xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_opcode(input string f, input opcode_t e, input opcode_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %0h, actual %0h", test_name, f, e, a);
        end
    endtask

    task automatic check_reg(input string f, input reg_addr_t e, input reg_addr_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %0d, actual %0d", test_name, f, e, a);
        end
    endtask

    task automatic check_funct3(input string f, input funct3_t e, input funct3_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %b, actual %b", test_name, f, e, a);
        end
    endtask

    task automatic check_funct7(input string f, input funct7_t e, input funct7_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %b, actual %b", test_name, f, e, a);
        end
    endtask

    task automatic check_xdata(input string f, input xdata_t e, input xdata_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, f, e, a);
        end
    endtask

    task automatic check_addr(input string f, input addr_t e, input addr_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, f, e, a);
        end
    endtask

    task automatic check_i_imm(input string f, input i_imm_t e, input i_imm_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, f, e, a);
        end
    endtask

    task automatic check_u_imm(input string f, input u_imm_t e, input u_imm_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, f, e, a);
        end
    endtask

    task automatic check_j_imm(input string f, input j_imm_t e, input j_imm_t a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, f, e, a);
        end
    endtask

    task automatic check_bit(input string f, input logic e, input logic a);
        if (e !== a) begin
            errors++;
            $display("Error %s %s: expected %b, actual %b", test_name, f, e, a);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic xdata_t model_operand(input reg_addr_t src);
        if (src == 0) return '0;
        if (exec_reg == src) return exec_data;
        if (wb_reg == src) return wb_data;
        return shadow[src];
    endfunction

    task automatic compare_output();
        item_t it;
        logic  cmp;
        logic  exc;
        logic  wr;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: the stage produced an output that was never presented", test_name);
            return;
        end
        it  = exp_q.pop_front();
        cmp = it.w[1:0] != 2'b11;
        exc = it.fx || cmp;
        // store, branch and system leave rd alone.
        wr  = it.w[6:2] != 5'b01000 && it.w[6:2] != 5'b11000 && it.w[6:2] != 5'b11100;
        check_opcode("opcode", opcode_t'(it.w[6:2]), opcode);
        check_reg("rd", it.w[11:7], rd);
        check_reg("rs1", it.w[19:15], rs1);
        check_reg("rs2", it.w[24:20], rs2);
        check_funct3("funct3", it.w[14:12], funct3);
        check_funct7("funct7", it.w[31:25], funct7);
        check_i_imm("i_imm", it.w[31:20], i_imm);
        check_u_imm("u_imm", it.w[31:12], u_imm);
        check_j_imm("j_imm", {it.w[31], it.w[19:12], it.w[20], it.w[30:21]}, j_imm);
        check_bit("is_jump", it.w[6] && it.w[5], is_jump);
        check_bit("is_compressed", cmp, is_compressed);
        check_bit("decode_exception", exc, decode_exception);
        check_bit("is_reg_write", wr && !exc, is_reg_write);
        check_addr("addr", it.a, instruction_addr_q);
        check_addr("next_addr", it.na, instruction_next_addr_q);
        check_xdata("rs1_data", it.v1, rs1_data);
        check_xdata("rs2_data", it.v2, rs2_data);
    endtask

    // inputs for the coming edge are already driven here.
    task automatic clock_edge();
        item_t it;
        accepted = 1'b0;
        if (flush) begin
            exp_q.delete();
        end else begin
            if (!stall_next && !next_stalled) begin
                compare_output();
            end
            accepted = !prev_stalled && !stall_prev;
            if (accepted) begin
                it.w  = instruction;
                it.a  = instruction_addr;
                it.na = instruction_next_addr;
                it.fx = ifetch_exception;
                it.v1 = model_operand(instruction[19:15]);
                it.v2 = model_operand(instruction[24:20]);
                exp_q.push_back(it);
            end
        end
        if (stall_prev && !last_stall_prev) begin
            check_bit("stall_prev rise", 1'b1, last_next_stalled && !last_stall_next);
        end
        if (stall_prev) begin
            check_bit("stall_prev with empty output", 1'b0, stall_next);
        end
        if (wb_reg != 0) begin
            shadow[wb_reg] = wb_data;
        end
        last_stall_prev   = stall_prev;
        last_stall_next   = stall_next;
        last_next_stalled = next_stalled;
        @(negedge clk);
    endtask

    task automatic present(input instr_t w, input logic fx);
        instruction           = w;
        instruction_addr      = xorshift() & 32'hffff_fffc;
        instruction_next_addr = instruction_addr + 4;
        ifetch_exception      = fx;
        prev_stalled          = 1'b0;
    endtask

    task automatic drain();
        prev_stalled = 1'b1;
        next_stalled = 1'b0;
        exec_reg     = '0;
        wb_reg       = '0;
        while (exp_q.size() != 0) begin
            clock_edge();
        end
        clock_edge();
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_field_decode();
        test_name = "field_decode";
        for (int n = 0; n < 200; n++) begin
            present(xorshift() | 32'h3, 1'b0);
            clock_edge();
            // one cycle latency leaves exactly the new item pending.
            check_bit("latency", 1'b1, exp_q.size() == 1 && !stall_next);
        end
        drain();
    endtask

    task automatic test_register_read();
        reg_addr_t s1;
        reg_addr_t s2;
        test_name = "register_read";
        prev_stalled = 1'b1;
        for (int r = 1; r < 32; r++) begin
            wb_reg  = reg_addr_t'(r);
            wb_data = xorshift();
            clock_edge();
        end
        wb_reg = '0;
        for (int n = 0; n < 20; n++) begin
            s1 = (n == 0) ? 5'd0 : reg_addr_t'(xorshift());
            s2 = reg_addr_t'(s1 + 1 + xorshift() % 31);
            present({7'd0, s2, s1, 3'd0, reg_addr_t'(xorshift()), 7'b0110011}, 1'b0);
            clock_edge();
        end
        drain();
    endtask

    task automatic test_bypass();
        test_name = "bypass";
        exec_data = xorshift();
        wb_data   = xorshift();
        exec_reg  = 5'd5;
        wb_reg    = 5'd7;
        present({7'd0, 5'd7, 5'd5, 3'd0, 5'd1, 7'b0110011}, 1'b0);
        clock_edge();
        wb_reg = 5'd5;
        present({7'd0, 5'd5, 5'd5, 3'd0, 5'd1, 7'b0110011}, 1'b0);
        clock_edge();
        exec_reg = '0;
        wb_reg   = '0;
        present({7'd0, 5'd0, 5'd0, 3'd0, 5'd1, 7'b0110011}, 1'b0);
        clock_edge();
        drain();
    endtask

    task automatic test_back_pressure();
        test_name = "back_pressure";
        present(xorshift() | 32'h3, 1'b0);
        for (int n = 0; n < 300; n++) begin
            if (accepted) begin
                present(xorshift() | 32'h3, 1'b0);
            end
            // fetch holds its item while stalled.
            if (!stall_prev) begin
                prev_stalled = xorshift() % 4 == 0;
            end
            next_stalled = xorshift() % 2 != 0;
            clock_edge();
        end
        drain();
    endtask

    task automatic test_exceptions();
        instr_t w;
        test_name = "exceptions";
        for (int n = 0; n < 40; n++) begin
            w = xorshift();
            if (n % 2 == 0) begin
                w[1:0] = 2'b11;
            end
            present(w, xorshift() % 3 == 0);
            clock_edge();
        end
        drain();
    endtask

    task automatic test_flush();
        test_name = "flush";
        next_stalled = 1'b1;
        for (int n = 0; n < 4; n++) begin
            if (n == 0 || accepted) begin
                present(xorshift() | 32'h3, 1'b0);
            end
            clock_edge();
        end
        check_bit("stall_prev before flush", 1'b1, stall_prev);
        flush        = 1'b1;
        prev_stalled = 1'b1;
        clock_edge();
        flush = 1'b0;
        check_bit("stall_next after flush", 1'b1, stall_next);
        check_bit("stall_prev after flush", 1'b0, stall_prev);
        next_stalled = 1'b0;
        for (int n = 0; n < 5; n++) begin
            present(xorshift() | 32'h3, 1'b0);
            clock_edge();
        end
        drain();
    endtask

    initial begin
        arst_n                = 1'b0;
        flush                 = 1'b0;
        instruction           = '0;
        instruction_addr      = '0;
        instruction_next_addr = '0;
        ifetch_exception      = 1'b0;
        prev_stalled          = 1'b1;
        next_stalled          = 1'b0;
        exec_reg              = '0;
        exec_data             = '0;
        wb_reg                = '0;
        wb_data               = '0;
        last_stall_prev       = 1'b0;
        last_stall_next       = 1'b1;
        last_next_stalled     = 1'b0;
        accepted              = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("stall_next after reset", 1'b1, stall_next);
        check_bit("stall_prev after reset", 1'b0, stall_prev);

        test_field_decode();
        test_register_read();
        test_bypass();
        test_back_pressure();
        test_exceptions();
        test_flush();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/decode_pkg.sv
design/skid_buffer.sv
design/reg_file.sv
design/field_decoder.sv
design/operand_fetch.sv
design/decode_commit.sv
design/decode_stage.sv
tb/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - design/decode_pkg.sv
  - design/skid_buffer.sv
  - design/reg_file.sv
  - design/field_decoder.sv
  - design/operand_fetch.sv
  - design/decode_commit.sv
  - design/decode_stage.sv
  - target: test
    files:
      - tb/tb_decode_stage.sv
